/* Bender.yml */
package:
  name: fsync_node

sources:
  - files:
      - hdl/fsync_pkg.sv
      - hdl/fsync_fifo.sv
      - hdl/fsync_rx.sv
      - hdl/fsync_match.sv
      - hdl/fsync_up.sv
      - hdl/fsync_down.sv
      - hdl/fsync_node.sv
  - target: simulation
    files:
      - bench/tb_fsync_node.sv

/* all.f */
hdl/fsync_pkg.sv
hdl/fsync_fifo.sv
hdl/fsync_rx.sv
hdl/fsync_match.sv
hdl/fsync_up.sv
hdl/fsync_down.sv
hdl/fsync_node.sv
bench/tb_fsync_node.sv

/* bench/tb_fsync_node.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fsync_node
  import fsync_pkg::*;
;

  localparam int unsigned ID_W   = DEF_ID_W;
  localparam int unsigned AGGR_W = DEF_AGGR_W;
  localparam int unsigned N_IDS  = 2 ** ID_W;
  localparam int TIMEOUT = 60;  // Cycles per wait loop

  localparam logic [AGGR_W-1:0] AG_LOC = 4'b0010;  // Target is this node
  localparam logic [AGGR_W-1:0] AG_UP  = 4'b0110;  // Target above
  localparam logic [AGGR_W-1:0] AG_BAD = 4'b0001;  // Level bit clear
  localparam int PRIO_LOC_ID = 3;
  localparam int PRIO_PAR_ID = 6;
  localparam int K_NONE  = 0;
  localparam int K_LOCAL = 1;
  localparam int K_UP    = 2;
  localparam int K_BAD   = 3;

  // One stimulus row, applied for one cycle
  typedef struct packed {
    logic              v0;
    logic [ID_W-1:0]   id0;
    logic [AGGR_W-1:0] ag0;
    logic              v1;
    logic [ID_W-1:0]   id1;
    logic [AGGR_W-1:0] ag1;
    logic              pv;   // Parent response
    logic [ID_W-1:0]   pid;
    logic              err;  // Row must raise error_o
  } row_t;

  logic              clk, rst_n;
  logic              req_valid [N_CHILDREN];
  logic [ID_W-1:0]   req_id    [N_CHILDREN];
  logic [AGGR_W-1:0] req_aggr  [N_CHILDREN];
  logic              up_valid, dn_valid, rsp_valid_par, error;
  logic [ID_W-1:0]   up_id, dn_id, rsp_id_par;
  logic [AGGR_W-1:0] up_aggr;

  row_t                    rows [$];
  logic [ID_W+AGGR_W:0]    exp_q [$];    // {is_up, id, aggr} with aggr zero for responses
  int                      rsp_log [$];  // Broadcast ids in order seen
  logic [N_CHILDREN-1:0]   pend [N_IDS]; // Reference arrival table
  logic [31:0]             lcg_state = 32'h92ad5986;

  fsync_node i_dut (
    .clk_i       ( clk           ),
    .rst_ni      ( rst_n         ),
    .req_valid_i ( req_valid     ),
    .req_id_i    ( req_id        ),
    .req_aggr_i  ( req_aggr      ),
    .rsp_valid_o ( dn_valid      ),
    .rsp_id_o    ( dn_id         ),
    .req_valid_o ( up_valid      ),
    .req_id_o    ( up_id         ),
    .req_aggr_o  ( up_aggr       ),
    .rsp_valid_i ( rsp_valid_par ),
    .rsp_id_i    ( rsp_id_par    ),
    .error_o     ( error         )
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Class rule against level 1
  function automatic int classify(input logic v, input logic [AGGR_W-1:0] ag);
    if (!v) return K_NONE;
    if (!ag[DEF_LVL]) return K_BAD;
    if ((ag >> (DEF_LVL + 1)) != 0) return K_UP;
    return K_LOCAL;
  endfunction

  task automatic complete(input logic [ID_W-1:0] id, input int k, input logic [AGGR_W-1:0] ag);
    pend[id] = '0;
    if (k == K_UP) exp_q.push_back({1'b1, id, ag});
    else           exp_q.push_back({1'b0, id, {AGGR_W{1'b0}}});
  endtask

  // Second arrival from the same port changes nothing
  task automatic note_arrival(input int p, input logic [ID_W-1:0] id, input int k,
                              input logic [AGGR_W-1:0] ag);
    if (!pend[id][p]) begin
      if (pend[id][1-p]) complete(id, k, ag);  // Partner waiting
      else               pend[id][p] = 1'b1;
    end
  endtask

  task automatic model_row(input row_t r);
    int c0, c1;
    c0 = classify(r.v0, r.ag0);
    c1 = classify(r.v1, r.ag1);
    if ((c0 == K_LOCAL || c0 == K_UP) && (c1 == K_LOCAL || c1 == K_UP) && r.id0 == r.id1) begin
      complete(r.id0, c0, r.ag0);  // Both in the same cycle
    end else begin
      if (c0 == K_LOCAL || c0 == K_UP) note_arrival(0, r.id0, c0, r.ag0);
      if (c1 == K_LOCAL || c1 == K_UP) note_arrival(1, r.id1, c1, r.ag1);
    end
    if (r.pv) exp_q.push_back({1'b0, r.pid, {AGGR_W{1'b0}}});
  endtask

  task automatic drive_row(input row_t r);
    req_valid[0] = r.v0;
    req_id[0]    = r.id0;
    req_aggr[0]  = r.ag0;
    req_valid[1] = r.v1;
    req_id[1]    = r.id1;
    req_aggr[1]  = r.ag1;
    rsp_valid_par = r.pv;
    rsp_id_par    = r.pid;
  endtask

  task automatic add_row(input logic v0, input int id0, input logic [AGGR_W-1:0] ag0,
                         input logic v1, input int id1, input logic [AGGR_W-1:0] ag1,
                         input logic pv, input int pid, input logic err);
    rows.push_back({v0, id0[ID_W-1:0], ag0, v1, id1[ID_W-1:0], ag1, pv, pid[ID_W-1:0], err});
  endtask

  // Idle until every expected output has shown up
  task automatic drain();
    int cyc;
    cyc = 0;
    @(negedge clk) drive_row('0);
    while (exp_q.size() != 0) begin
      @(negedge clk);
      cyc++;
      if (cyc > TIMEOUT) begin
        $display("%0d expected outputs never arrived by %0t", exp_q.size(), $time);
        stop_run();
      end
    end
    repeat (4) @(negedge clk);  // Room for anything unexpected
  endtask

  task automatic wait_for_error();
    int cyc;
    cyc = 0;
    while (!error) begin
      @(negedge clk) drive_row('0);
      cyc++;
      if (cyc > TIMEOUT) begin
        $display("error_o never rose after a faulty request, at %0t", $time);
        stop_run();
      end
    end
    repeat (4) @(negedge clk) check_value("error_o", error, 1);  // Sticky
  endtask

  task automatic reset_dut();
    @(negedge clk);
    drive_row('0);
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    check_value("error_o", error, 0);
    for (int i = 0; i < N_IDS; i++) pend[i] = '0;
    rst_n = 1'b1;
  endtask

  // Parent response must come right before the local one it displaced
  task automatic check_priority_order();
    int idx;
    idx = -1;
    for (int i = 0; i < rsp_log.size(); i++) begin
      if (idx < 0 && rsp_log[i] == PRIO_PAR_ID) idx = i;
    end
    if (idx < 0 || idx + 1 >= rsp_log.size()) begin
      $display("Parent response %0d missing or not followed by a local one", PRIO_PAR_ID);
      stop_run();
    end else begin
      check_value("rsp_id_o after parent response", rsp_log[idx+1], PRIO_LOC_ID);
    end
  endtask

  // Interleaved arrivals for n distinct ids with one port per row
  task automatic build_random(input int n_ids);
    logic [7:0]        ev [$];  // {port, id, aggr}
    logic [7:0]        tmp;
    logic [AGGR_W-1:0] ag;
    int                perm [N_IDS];
    int                pt;
    int                j;
    for (int i = 0; i < N_IDS; i++) perm[i] = i;
    for (int i = N_IDS - 1; i > 0; i--) begin
      j = int'(next_random() >> 8) % (i + 1);
      pt = perm[i];
      perm[i] = perm[j];
      perm[j] = pt;
    end
    for (int k = 0; k < n_ids; k++) begin
      ag = (next_random() >> 20) & 1 ? AG_UP : AG_LOC;
      ev.push_back({1'b0, perm[k][ID_W-1:0], ag});
      ev.push_back({1'b1, perm[k][ID_W-1:0], ag});
    end
    for (int i = ev.size() - 1; i > 0; i--) begin
      j = int'(next_random() >> 8) % (i + 1);
      tmp = ev[i];
      ev[i] = ev[j];
      ev[j] = tmp;
    end
    foreach (ev[i]) begin
      if (ev[i][7]) add_row(0, 0, '0, 1, ev[i][6:4], ev[i][3:0], 0, 0, 0);
      else          add_row(1, ev[i][6:4], ev[i][3:0], 0, 0, '0, 0, 0, 0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output monitors sampled away from the rising edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic take_expected(input logic [ID_W+AGGR_W:0] item, input string what);
    int hit;
    hit = -1;
    foreach (exp_q[i]) if (hit < 0 && exp_q[i] == item) hit = i;
    if (hit < 0) begin
      $display("Unexpected %s, id %0d aggr %b, at %0t", what, item[AGGR_W+:ID_W],
               item[AGGR_W-1:0], $time);
      stop_run();
    end else begin
      exp_q.delete(hit);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && up_valid) take_expected({1'b1, up_id, up_aggr}, "request to parent");
    if (rst_n && dn_valid) begin
      take_expected({1'b0, dn_id, {AGGR_W{1'b0}}}, "response to children");
      rsp_log.push_back(dn_id);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table and main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst_n = 1'b0;
    drive_row('0);
    for (int i = 0; i < N_IDS; i++) pend[i] = '0;
    add_row(1, 1, AG_LOC, 1, 1, AG_LOC, 0, 0, 0);  // Local, same cycle
    add_row(1, 2, AG_LOC, 0, 0, '0, 0, 0, 0);      // Local, ws two cycles later
    add_row(0, 0, '0, 0, 0, '0, 0, 0, 0);
    add_row(0, 0, '0, 1, 2, AG_LOC, 0, 0, 0);
    add_row(0, 0, '0, 1, 4, AG_UP, 0, 0, 0);       // Merged upward
    add_row(1, 4, AG_UP, 0, 0, '0, 0, 0, 0);
    add_row(1, 0, AG_UP, 0, 0, '0, 0, 0, 0);       // Lone arrival, stays pending
    add_row(0, 0, '0, 0, 0, '0, 1, 5, 0);          // Parent broadcast alone
    repeat (4) add_row(0, 0, '0, 0, 0, '0, 0, 0, 0);
    add_row(1, PRIO_LOC_ID, AG_LOC, 1, PRIO_LOC_ID, AG_LOC, 0, 0, 0);
    add_row(0, 0, '0, 0, 0, '0, 0, 0, 0);
    add_row(0, 0, '0, 0, 0, '0, 1, PRIO_PAR_ID, 0); // Lands on the local slot
    add_row(1, 2, AG_BAD, 0, 0, '0, 0, 0, 1);      // Level bit clear
    add_row(1, 5, AG_LOC, 0, 0, '0, 0, 0, 0);
    add_row(1, 5, AG_LOC, 0, 0, '0, 0, 0, 1);      // Same port twice
    build_random(6);

    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    foreach (rows[i]) begin
      if (rows[i].err) drain();  // Nothing in flight across the reset
      @(negedge clk);
      check_value("error_o", error, 0);
      drive_row(rows[i]);
      model_row(rows[i]);
      if (rows[i].err) begin
        wait_for_error();
        reset_dut();
      end
    end
    drain();
    check_value("error_o", error, 0);
    check_priority_order();

    if (exp_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* hdl/fsync_down.sv */
`timescale 1ns/1ps
`default_nettype none

module fsync_down
  import fsync_pkg::*;
#(
  parameter int unsigned ID_W       = DEF_ID_W,
  parameter int unsigned FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            rsp_valid_i,              // From parent
  input  wire logic [ID_W-1:0] rsp_id_i,
  input  wire logic            loc_push_i [N_CHILDREN],  // Local completions
  input  wire logic [ID_W-1:0] loc_id_i   [N_CHILDREN],
  output logic                 rsp_valid_o,              // To both children
  output logic      [ID_W-1:0] rsp_id_o,
  output logic                 ovf_o
);

  logic            q_push [N_CHILDREN];
  logic            q_pop, q_empty;
  logic [ID_W-1:0] q_head;
  logic            byp    [N_CHILDREN];  // Straight to output, queue idle
  logic            rsp_valid_d, rsp_valid_q;
  logic [ID_W-1:0] rsp_id_d, rsp_id_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output select, parent first
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    byp[0] = !rsp_valid_i && q_empty && loc_push_i[0];
    byp[1] = !rsp_valid_i && q_empty && !loc_push_i[0] && loc_push_i[1];
    q_pop  = !rsp_valid_i && !q_empty;  // Oldest local completion next

    for (int i = 0; i < N_CHILDREN; i++) begin
      q_push[i] = loc_push_i[i] && !byp[i];
    end

    rsp_valid_d = 1'b1;
    if (rsp_valid_i) begin
      rsp_id_d = rsp_id_i;
    end else if (!q_empty) begin
      rsp_id_d = q_head;
    end else if (byp[0]) begin
      rsp_id_d = loc_id_i[0];
    end else if (byp[1]) begin
      rsp_id_d = loc_id_i[1];
    end else begin
      rsp_valid_d = 1'b0;  // Nothing to send
      rsp_id_d    = rsp_id_q;
    end
  end

  fsync_fifo #(
    .DATA_W     ( ID_W       ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .push_i  ( q_push   ),
    .data_i  ( loc_id_i ),
    .pop_i   ( q_pop    ),
    .empty_o ( q_empty  ),
    .data_o  ( q_head   ),
    .ovf_o   ( ovf_o    )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rsp_valid_q <= 1'b0;
    else         rsp_valid_q <= rsp_valid_d;
  end

  always_ff @(posedge clk_i) begin
    rsp_id_q <= rsp_id_d;  // Only meaningful with valid
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o    = rsp_id_q;

endmodule

`default_nettype wire

/* hdl/fsync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fsync_fifo
  import fsync_pkg::*;
#(
  parameter int unsigned DATA_W     = 8,
  parameter int unsigned FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              push_i [N_CHILDREN],  // In port order
  input  wire logic [DATA_W-1:0] data_i [N_CHILDREN],
  input  wire logic              pop_i,
  output logic                   empty_o,
  output logic      [DATA_W-1:0] data_o,             // Head, combinational
  output logic                   ovf_o               // Push dropped while full
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = PTR_W + 1;

  logic [DATA_W-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  rd_ptr_q, wr_ptr_q, wr_ptr_d;
  logic [CNT_W-1:0]  cnt_q, cnt_d;
  logic [CNT_W-1:0]  room, n_acc;
  logic              do_pop;
  logic              wr_en  [N_CHILDREN];
  logic [PTR_W-1:0]  wr_idx [N_CHILDREN];

  // Wrap at FIFO_DEPTH, also for depths that are no power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_pop  = pop_i && !empty_o;  // Pop on empty is ignored

  // Accept pushes in order while room is left; popped slot counts as free
  always_comb begin
    room     = CNT_W'(FIFO_DEPTH) - cnt_q + {{(CNT_W-1){1'b0}}, do_pop};
    n_acc    = '0;
    wr_ptr_d = wr_ptr_q;
    ovf_o    = 1'b0;
    for (int i = 0; i < N_CHILDREN; i++) begin
      wr_en[i]  = 1'b0;
      wr_idx[i] = wr_ptr_d;
      if (push_i[i]) begin
        if (n_acc < room) begin
          wr_en[i] = 1'b1;
          n_acc    = n_acc + 1'b1;
          wr_ptr_d = ptr_inc(wr_ptr_d);
        end else begin
          ovf_o = 1'b1;  // Entry lost
        end
      end
    end
    cnt_d = cnt_q + n_acc - {{(CNT_W-1){1'b0}}, do_pop};
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      wr_ptr_q <= wr_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N_CHILDREN; i++) begin
      if (wr_en[i]) mem_q[wr_idx[i]] <= data_i[i];
    end
  end

endmodule

`default_nettype wire

/* hdl/fsync_match.sv */
`timescale 1ns/1ps
`default_nettype none

module fsync_match
  import fsync_pkg::*;
#(
  parameter int unsigned AGGR_W = DEF_AGGR_W,
  parameter int unsigned ID_W   = DEF_ID_W
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire req_class_e        cls_i      [N_CHILDREN],
  input  wire logic [ID_W-1:0]   id_i       [N_CHILDREN],
  input  wire logic [AGGR_W-1:0] aggr_i     [N_CHILDREN],
  output logic                   up_push_o  [N_CHILDREN],  // Port 0 first
  output logic      [ID_W-1:0]   up_id_o    [N_CHILDREN],
  output logic      [AGGR_W-1:0] up_aggr_o  [N_CHILDREN],
  output logic                   loc_push_o [N_CHILDREN],
  output logic      [ID_W-1:0]   loc_id_o   [N_CHILDREN],
  output logic                   dup_err_o,
  output logic                   lvl_err_o
);

  localparam int unsigned N_IDS = 2 ** ID_W;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arrival table, one bit per child and id
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [N_CHILDREN-1:0] arr_q [N_IDS];

  logic                  vld    [N_CHILDREN];
  logic                  done   [N_CHILDREN];  // Barrier completes on this port
  logic                  set_en [N_CHILDREN];  // First arrival, mark it
  logic                  same;                 // Both ports, same id, same cycle
  logic                  dup_err, lvl_err;

  logic                  up_push_q  [N_CHILDREN];
  logic                  loc_push_q [N_CHILDREN];
  logic [ID_W-1:0]       id_q       [N_CHILDREN];
  logic [AGGR_W-1:0]     aggr_q     [N_CHILDREN];
  logic                  dup_err_q, lvl_err_q;

  always_comb begin
    lvl_err = 1'b0;
    for (int i = 0; i < N_CHILDREN; i++) begin
      vld[i]  = (cls_i[i] == CLS_LOCAL) || (cls_i[i] == CLS_UP);
      lvl_err = lvl_err || (cls_i[i] == CLS_BAD);
    end
  end

  always_comb begin
    same    = vld[0] && vld[1] && (id_i[0] == id_i[1]);
    dup_err = 1'b0;
    for (int i = 0; i < N_CHILDREN; i++) begin
      done[i]   = 1'b0;
      set_en[i] = 1'b0;
    end
    if (same) begin
      done[0] = 1'b1;                 // One completion, carried on slot 0
      dup_err = |arr_q[id_i[0]];      // Some port was already waiting
    end else begin
      // Different ids here, so the two ports never touch the same entry
      for (int i = 0; i < N_CHILDREN; i++) begin
        if (vld[i]) begin
          if (arr_q[id_i[i]][i]) begin
            dup_err = 1'b1;                               // Arrived twice
          end else if (arr_q[id_i[i]][N_CHILDREN-1-i]) begin
            done[i] = 1'b1;                               // Partner waiting
          end else begin
            set_en[i] = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < N_IDS; k++) arr_q[k] <= '0;
    end else begin
      for (int i = 0; i < N_CHILDREN; i++) begin
        if (set_en[i]) arr_q[id_i[i]][i] <= 1'b1;
        if (done[i])   arr_q[id_i[i]]    <= '0;  // Entry free again
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Completion routing by class
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_CHILDREN; i++) begin
        up_push_q[i]  <= 1'b0;
        loc_push_q[i] <= 1'b0;
      end
      dup_err_q <= 1'b0;
      lvl_err_q <= 1'b0;
    end else begin
      for (int i = 0; i < N_CHILDREN; i++) begin
        up_push_q[i]  <= done[i] && (cls_i[i] == CLS_UP);
        loc_push_q[i] <= done[i] && (cls_i[i] == CLS_LOCAL);
      end
      dup_err_q <= dup_err;
      lvl_err_q <= lvl_err;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q   <= id_i;
    aggr_q <= aggr_i;  // Merged request keeps the arriving aggregate
  end

  assign up_push_o  = up_push_q;
  assign up_id_o    = id_q;
  assign up_aggr_o  = aggr_q;
  assign loc_push_o = loc_push_q;
  assign loc_id_o   = id_q;
  assign dup_err_o  = dup_err_q;
  assign lvl_err_o  = lvl_err_q;

endmodule

`default_nettype wire

/* hdl/fsync_node.sv */
`timescale 1ns/1ps
`default_nettype none

module fsync_node
  import fsync_pkg::*;
#(
  parameter int unsigned AGGR_W     = DEF_AGGR_W,
  parameter int unsigned ID_W       = DEF_ID_W,
  parameter int unsigned LVL        = DEF_LVL,
  parameter int unsigned FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // Children, en on 0 and ws on 1
  input  wire logic              req_valid_i [N_CHILDREN],
  input  wire logic [ID_W-1:0]   req_id_i    [N_CHILDREN],
  input  wire logic [AGGR_W-1:0] req_aggr_i  [N_CHILDREN],
  output logic                   rsp_valid_o,
  output logic      [ID_W-1:0]   rsp_id_o,
  // Parent
  output logic                   req_valid_o,
  output logic      [ID_W-1:0]   req_id_o,
  output logic      [AGGR_W-1:0] req_aggr_o,
  input  wire logic              rsp_valid_i,
  input  wire logic [ID_W-1:0]   rsp_id_i,
  output logic                   error_o       // Sticky until reset
);

  req_class_e             rx_cls   [N_CHILDREN];
  logic      [ID_W-1:0]   rx_id    [N_CHILDREN];
  logic      [AGGR_W-1:0] rx_aggr  [N_CHILDREN];
  logic                   up_push  [N_CHILDREN];
  logic      [ID_W-1:0]   up_id    [N_CHILDREN];
  logic      [AGGR_W-1:0] up_aggr  [N_CHILDREN];
  logic                   loc_push [N_CHILDREN];
  logic      [ID_W-1:0]   loc_id   [N_CHILDREN];
  logic      [N_ERR-1:0]  err_pulse;
  logic                   error_q;

  fsync_rx #(
    .AGGR_W ( AGGR_W ),
    .ID_W   ( ID_W   ),
    .LVL    ( LVL    )
  ) i_rx (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_id_i    ( req_id_i    ),
    .req_aggr_i  ( req_aggr_i  ),
    .cls_o       ( rx_cls      ),
    .id_o        ( rx_id       ),
    .aggr_o      ( rx_aggr     )
  );

  fsync_match #(
    .AGGR_W ( AGGR_W ),
    .ID_W   ( ID_W   )
  ) i_match (
    .clk_i      ( clk_i              ),
    .rst_ni     ( rst_ni             ),
    .cls_i      ( rx_cls             ),
    .id_i       ( rx_id              ),
    .aggr_i     ( rx_aggr            ),
    .up_push_o  ( up_push            ),
    .up_id_o    ( up_id              ),
    .up_aggr_o  ( up_aggr            ),
    .loc_push_o ( loc_push           ),
    .loc_id_o   ( loc_id             ),
    .dup_err_o  ( err_pulse[ERR_DUP] ),
    .lvl_err_o  ( err_pulse[ERR_LVL] )
  );

  fsync_up #(
    .AGGR_W     ( AGGR_W     ),
    .ID_W       ( ID_W       ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_up (
    .clk_i       ( clk_i                 ),
    .rst_ni      ( rst_ni                ),
    .up_push_i   ( up_push               ),
    .up_id_i     ( up_id                 ),
    .up_aggr_i   ( up_aggr               ),
    .req_valid_o ( req_valid_o           ),
    .req_id_o    ( req_id_o              ),
    .req_aggr_o  ( req_aggr_o            ),
    .ovf_o       ( err_pulse[ERR_UP_OVF] )
  );

  fsync_down #(
    .ID_W       ( ID_W       ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_down (
    .clk_i       ( clk_i                 ),
    .rst_ni      ( rst_ni                ),
    .rsp_valid_i ( rsp_valid_i           ),
    .rsp_id_i    ( rsp_id_i              ),
    .loc_push_i  ( loc_push              ),
    .loc_id_i    ( loc_id                ),
    .rsp_valid_o ( rsp_valid_o           ),
    .rsp_id_o    ( rsp_id_o              ),
    .ovf_o       ( err_pulse[ERR_DN_OVF] )
  );

  // Any error pulse latches the flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)         error_q <= 1'b0;
    else if (|err_pulse) error_q <= 1'b1;
  end

  assign error_o = error_q;

endmodule

`default_nettype wire

/* hdl/fsync_pkg.sv */
`default_nettype none

package fsync_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Node geometry and default widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned N_CHILDREN     = 2;  // en and ws ports
  localparam int unsigned DEF_AGGR_W     = 4;  // One bit per tree level
  localparam int unsigned DEF_ID_W       = 3;  // Barrier id
  localparam int unsigned DEF_LVL        = 1;  // Level of this node
  localparam int unsigned DEF_FIFO_DEPTH = 4;

  // Request class, decoded from the aggregate field
  typedef enum logic [1:0] {
    CLS_NONE  = 2'd0,  // No request this cycle
    CLS_LOCAL = 2'd1,  // This node is the target
    CLS_UP    = 2'd2,  // Merge, then forward to parent
    CLS_BAD   = 2'd3   // Level bit clear
  } req_class_e;

  // Error sources, index into the node's error vector
  typedef enum logic [1:0] {
    ERR_LVL    = 2'd0,
    ERR_DUP    = 2'd1,
    ERR_UP_OVF = 2'd2,
    ERR_DN_OVF = 2'd3
  } err_e;

  localparam int unsigned N_ERR = 4;

endpackage

`default_nettype wire

/* hdl/fsync_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module fsync_rx
  import fsync_pkg::*;
#(
  parameter int unsigned AGGR_W = DEF_AGGR_W,
  parameter int unsigned ID_W   = DEF_ID_W,
  parameter int unsigned LVL    = DEF_LVL
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              req_valid_i [N_CHILDREN],
  input  wire logic [ID_W-1:0]   req_id_i    [N_CHILDREN],
  input  wire logic [AGGR_W-1:0] req_aggr_i  [N_CHILDREN],
  output req_class_e             cls_o       [N_CHILDREN],
  output logic      [ID_W-1:0]   id_o        [N_CHILDREN],
  output logic      [AGGR_W-1:0] aggr_o      [N_CHILDREN]
);

  // Bits at and below this level, and the bits above it
  localparam logic [AGGR_W-1:0] LOW_MASK = (AGGR_W'(1) << (LVL + 1)) - AGGR_W'(1);
  localparam logic [AGGR_W-1:0] HI_MASK  = ~LOW_MASK;

  req_class_e            cls_d  [N_CHILDREN];
  req_class_e            cls_q  [N_CHILDREN];
  logic      [ID_W-1:0]   id_q   [N_CHILDREN];
  logic      [AGGR_W-1:0] aggr_q [N_CHILDREN];

  // Class decode on the raw request
  always_comb begin
    for (int i = 0; i < N_CHILDREN; i++) begin
      if (!req_valid_i[i]) begin
        cls_d[i] = CLS_NONE;
      end else if (!req_aggr_i[i][LVL]) begin
        cls_d[i] = CLS_BAD;                     // Not meant for this subtree
      end else if ((req_aggr_i[i] & HI_MASK) == '0) begin
        cls_d[i] = CLS_LOCAL;                   // Stops here
      end else begin
        cls_d[i] = CLS_UP;                      // Goes further up
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_CHILDREN; i++) cls_q[i] <= CLS_NONE;
    end else begin
      cls_q <= cls_d;
    end
  end

  // Payload follows the class
  always_ff @(posedge clk_i) begin
    id_q   <= req_id_i;
    aggr_q <= req_aggr_i;
  end

  assign cls_o  = cls_q;
  assign id_o   = id_q;
  assign aggr_o = aggr_q;

endmodule

`default_nettype wire

/* hdl/fsync_up.sv */
`timescale 1ns/1ps
`default_nettype none

module fsync_up
  import fsync_pkg::*;
#(
  parameter int unsigned AGGR_W     = DEF_AGGR_W,
  parameter int unsigned ID_W       = DEF_ID_W,
  parameter int unsigned FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              up_push_i [N_CHILDREN],
  input  wire logic [ID_W-1:0]   up_id_i   [N_CHILDREN],
  input  wire logic [AGGR_W-1:0] up_aggr_i [N_CHILDREN],
  output logic                   req_valid_o,
  output logic      [ID_W-1:0]   req_id_o,
  output logic      [AGGR_W-1:0] req_aggr_o,
  output logic                   ovf_o
);

  localparam int unsigned DATA_W = ID_W + AGGR_W;

  logic [DATA_W-1:0] push_data [N_CHILDREN];
  logic [DATA_W-1:0] head;
  logic              empty;

  // Pack id above aggregate
  always_comb begin
    for (int i = 0; i < N_CHILDREN; i++) push_data[i] = {up_id_i[i], up_aggr_i[i]};
  end

  fsync_fifo #(
    .DATA_W     ( DATA_W     ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .push_i  ( up_push_i   ),
    .data_i  ( push_data   ),
    .pop_i   ( req_valid_o ),  // No back-pressure, drain every cycle
    .empty_o ( empty       ),
    .data_o  ( head        ),
    .ovf_o   ( ovf_o       )
  );

  assign req_valid_o           = !empty;
  assign {req_id_o, req_aggr_o} = head;

endmodule

`default_nettype wire
